/* build.f */
design/upm_pkg.sv
design/upm_load_sequencer.sv
design/upm_cfg_capture.sv
design/upm_system_controller.sv
design/upm_event_counter.sv
design/upm_result_capture.sv
design/upm_top.sv
dv/upm_tb.sv

/* design/upm_cfg_capture.sv */
// two flop synchronizer followed by a load enabled holding register
`timescale 1ns/10ps

module upm_cfg_capture #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     dfx_upm_func_clk_cg,
	input  logic     dfx_upm_sys_rstn,
	input  logic     load_i,
	input  payload_t data_i,
	output payload_t data_o
);

	payload_t sync1_q;
	payload_t sync2_q;
	payload_t hold_q;

	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			sync1_q <= '0;
			sync2_q <= '0;
			hold_q  <= '0;
		end else begin
			// field is quasi static, sampled every cycle
			sync1_q <= data_i;
			sync2_q <= sync1_q;
			// update only on the selected strobe
			if (load_i) begin
				hold_q <= sync2_q;
			end
		end
	end

	assign data_o = hold_q;

	// held value moves only right after a load strobe
	a_hold_on_load: assert property (
		@(posedge dfx_upm_func_clk_cg) disable iff (!dfx_upm_sys_rstn)
		!$stable(data_o) |-> $past(load_i)
	);

endmodule

/* design/upm_event_counter.sv */
// two channel event counter with prescaler, window countdown and sticky overflow
`timescale 1ns/10ps

module upm_event_counter #(
	parameter int WINDOW_BITS  = upm_pkg::upm_window_bits_p,
	parameter int COUNTER_BITS = upm_pkg::upm_counter_bits_p
) (
	input  logic                          dfx_upm_func_clk_cg,
	input  logic                          dfx_upm_sys_rstn,
	input  logic                          start_i,
	input  logic                          stop_i,
	input  logic                          window_mode_i,
	input  logic [upm_pkg::upm_divider_hi_pos-upm_pkg::upm_divider_lo_pos:0] divider_i,
	input  logic [WINDOW_BITS-1:0]        window_count_i,
	input  logic [1:0]                    event_i,
	output logic [COUNTER_BITS-1:0]       count0_o,
	output logic [COUNTER_BITS-1:0]       count1_o,
	output logic [1:0]                    overflow_o,
	output upm_pkg::upm_cnt_state_t       state_o,
	output logic                          active_o,
	output logic                          enable_o,
	output logic [WINDOW_BITS-1:0]        window_left_o
);
	import upm_pkg::*;

	localparam int DIV_W = upm_divider_hi_pos - upm_divider_lo_pos + 1;

	upm_cnt_state_t state_q;
	logic start_q;
	logic start_rise;
	logic run_en;
	logic tick;
	logic window_end;
	logic [DIV_W-1:0] presc_q;
	logic [WINDOW_BITS-1:0] window_q;
	logic [COUNTER_BITS-1:0] count_q [2];
	logic [1:0] ovf_q;

	// start edge is ignored while stop is asserted
	assign start_rise = start_i & ~start_q & ~stop_i;
	// last window cycle, or an empty window
	assign window_end = window_mode_i && (window_q <= WINDOW_BITS'(1));
	assign run_en = (state_q == CNT_RUN) && !stop_i && !(window_mode_i && window_q == '0);
	// prescaler tick every divider+1 cycles
	assign tick = run_en && (presc_q == divider_i);

	//----------------------------------------
	// state machine
	//----------------------------------------
	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			state_q <= CNT_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= start_i;
			if (stop_i) begin
				state_q <= CNT_DONE;
			end else if (start_rise) begin
				state_q <= CNT_RUN;
			end else if (state_q == CNT_RUN && window_end) begin
				state_q <= CNT_DONE;
			end
		end
	end

	//----------------------------------------
	// prescaler, window and counters
	//----------------------------------------
	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			presc_q    <= '0;
			window_q   <= '0;
			ovf_q      <= '0;
			count_q[0] <= '0;
			count_q[1] <= '0;
		end else if (start_rise) begin
			// fresh measurement
			presc_q    <= '0;
			window_q   <= window_count_i;
			ovf_q      <= '0;
			count_q[0] <= '0;
			count_q[1] <= '0;
		end else if (run_en) begin
			presc_q <= tick ? '0 : presc_q + 1'b1;
			if (window_mode_i) begin
				window_q <= window_q - 1'b1;
			end
			for (int ch = 0; ch < 2; ch++) begin
				if (tick && event_i[ch]) begin
					count_q[ch] <= count_q[ch] + 1'b1;
					// wrap from all ones is sticky
					if (&count_q[ch]) begin
						ovf_q[ch] <= 1'b1;
					end
				end
			end
		end
	end

	assign count0_o      = count_q[0];
	assign count1_o      = count_q[1];
	assign overflow_o    = ovf_q;
	assign state_o       = state_q;
	assign active_o      = (state_q == CNT_RUN);
	assign enable_o      = start_i;
	assign window_left_o = window_q;

	// encoding 3 is unused
	a_state_legal: assert property (
		@(posedge dfx_upm_func_clk_cg) disable iff (!dfx_upm_sys_rstn)
		state_q != 2'd3
	);

endmodule

/* design/upm_load_sequencer.sv */
// sys_en synchronizer, rising edge detect and staged load strobes
`timescale 1ns/10ps

module upm_load_sequencer (
	input  logic dfx_upm_func_clk_cg,
	input  logic dfx_upm_sys_rstn,
	input  logic sys_en_i,
	output logic en_sync_o,
	output logic cfg_capture_o,
	output logic cbb_load_o,
	output logic ctl_load_o,
	output logic cfg_update_o
);
	import upm_pkg::*;

	// sys_en pipeline, stages 1 and 2 are the metastability flops
	logic [4:1] sys_en_q;
	logic load_pulse;
	// load strobe chain, bit n is high n cycles after the load pulse
	logic [upm_update_stage:1] load_chain_q;

	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			sys_en_q     <= '0;
			load_chain_q <= '0;
		end else begin
			sys_en_q     <= {sys_en_q[3:1], sys_en_i};
			load_chain_q <= {load_chain_q[upm_update_stage-1:1], load_pulse};
		end
	end

	// rising edge of the synchronized enable
	assign load_pulse = sys_en_q[3] & ~sys_en_q[4];

	assign en_sync_o     = sys_en_q[3];
	assign cfg_capture_o = load_chain_q[upm_capture_stage];
	assign cbb_load_o    = load_chain_q[upm_cbb_load_stage];
	assign ctl_load_o    = load_chain_q[upm_ctl_load_stage];
	assign cfg_update_o  = load_chain_q[upm_update_stage];

	//----------------------------------------
	// checks
	//----------------------------------------
	// edge detect gives a single cycle pulse per enable rise
	a_load_single_cycle: assert property (
		@(posedge dfx_upm_func_clk_cg) disable iff (!dfx_upm_sys_rstn)
		load_pulse |=> !load_pulse
	);

endmodule

/* design/upm_pkg.sv */
// shared definitions for the UPM system controller
// control word field map, counter widths, strobe chain taps and counter state

package upm_pkg;

	// default widths, the top level overrides them
	parameter int upm_window_bits_p  = 16;
	parameter int upm_counter_bits_p = 20;

	// control word layout
	parameter int upm_window_mode_pos = 0;
	parameter int upm_start_pos       = 1;
	parameter int upm_stop_pos        = 2;
	parameter int upm_divider_lo_pos  = 3;
	parameter int upm_divider_hi_pos  = 7;
	parameter int upm_window_lo_pos   = 8;

	// 9 fixed bits plus the window count field
	function automatic int upm_ctl_width_f(input int window_bits);
		return window_bits + 9;
	endfunction

	// debug enable sits on the top bit of the control word
	function automatic int upm_debug_pos(input int window_bits);
		return window_bits + 8;
	endfunction

	typedef logic [15:0] upm_cbb_addr_t;
	typedef logic [3:0]  upm_cbb_pwr_t;
	typedef logic [15:0] upm_cbb_pwr_en_t;

	typedef enum logic [1:0] {
		CNT_IDLE = 2'd0,
		CNT_RUN  = 2'd1,
		CNT_DONE = 2'd2
	} upm_cnt_state_t;

	// taps on the load strobe chain
	parameter int upm_capture_stage  = 1;
	parameter int upm_cbb_load_stage = 6;
	parameter int upm_ctl_load_stage = 9;
	parameter int upm_update_stage   = 10;

endpackage

/* design/upm_result_capture.sv */
// result and status registers, sampled while the enable is synchronized high
`timescale 1ns/10ps

module upm_result_capture #(
	parameter int WINDOW_BITS  = upm_pkg::upm_window_bits_p,
	parameter int COUNTER_BITS = upm_pkg::upm_counter_bits_p
) (
	input  logic                        dfx_upm_func_clk_cg,
	input  logic                        dfx_upm_sys_rstn,
	input  logic                        en_sync_i,
	input  logic [COUNTER_BITS-1:0]     count0_i,
	input  logic [COUNTER_BITS-1:0]     count1_i,
	input  logic [1:0]                  overflow_i,
	input  upm_pkg::upm_cnt_state_t     state_i,
	input  logic                        active_i,
	input  logic                        enable_i,
	input  logic [WINDOW_BITS-1:0]      window_left_i,
	output logic [2*COUNTER_BITS+1:0]   result_o,
	output logic [WINDOW_BITS+3:0]      status_o
);

	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			result_o <= '0;
			status_o <= '0;
		end else if (en_sync_i) begin
			// channel 1 in the upper half, each with its overflow on top
			result_o <= {overflow_i[1], count1_i, overflow_i[0], count0_i};
			status_o <= {active_i, enable_i, state_i, window_left_i};
		end else begin
			// nothing visible once sys_en drops
			result_o <= '0;
			status_o <= '0;
		end
	end

endmodule

/* design/upm_system_controller.sv */
// system mode logic, manual mode hold bit and tap master synchronizer
// power select decode and gating of all system outputs
`timescale 1ns/10ps

module upm_system_controller #(
	parameter int WINDOW_BITS = upm_pkg::upm_window_bits_p
) (
	input  logic                                             dfx_upm_func_clk_cg,
	input  logic                                             dfx_upm_sys_rstn,
	input  logic                                             en_sync_i,
	input  logic                                             tap_master_mode_i,
	input  logic                                             cfg_capture_i,
	input  logic                                             cfg_update_i,
	input  logic [upm_pkg::upm_ctl_width_f(WINDOW_BITS)-1:0] sys_ctl_i,
	input  upm_pkg::upm_cbb_addr_t                           cbb_addr_i,
	input  upm_pkg::upm_cbb_pwr_t                            cbb_pwr_i,
	output logic                                             system_mode_o,
	output logic                                             window_mode_o,
	output logic                                             counter_start_o,
	output logic                                             counter_stop_o,
	output logic [upm_pkg::upm_divider_hi_pos-upm_pkg::upm_divider_lo_pos:0] clock_divider_o,
	output logic [WINDOW_BITS-1:0]                           window_count_o,
	output logic                                             debug_clk_en_o,
	output upm_pkg::upm_cbb_pwr_en_t                         cbb_pwr_en_o,
	output upm_pkg::upm_cbb_addr_t                           cbb_addr_o,
	output logic                                             cfg_capture_o,
	output logic                                             cfg_update_o
);
	import upm_pkg::*;

	logic manual_mode;
	logic hold_q;
	logic tap_master_q;
	logic sys_mode;
	upm_cbb_pwr_en_t pwr_en_dec;

	// manual mode keeps the system outputs alive after sys_en drops
	assign manual_mode = sys_ctl_i[upm_window_mode_pos] & sys_ctl_i[upm_start_pos] &
		~sys_ctl_i[upm_stop_pos];

	always_ff @(posedge dfx_upm_func_clk_cg or negedge dfx_upm_sys_rstn) begin
		if (!dfx_upm_sys_rstn) begin
			hold_q       <= 1'b0;
			tap_master_q <= 1'b0;
		end else begin
			// hold bit refreshed at the end of each load sequence
			if (cfg_update_i) begin
				hold_q <= manual_mode;
			end
			// single flop, tap master mode is quasi static
			tap_master_q <= tap_master_mode_i;
		end
	end

	assign sys_mode = ~tap_master_q & (en_sync_i | hold_q);

	// one hot decode of the power select
	assign pwr_en_dec = upm_cbb_pwr_en_t'(1) << cbb_pwr_i;

	//----------------------------------------
	// output gating, zero outside system mode
	//----------------------------------------
	assign system_mode_o   = sys_mode;
	assign window_mode_o   = sys_mode & sys_ctl_i[upm_window_mode_pos];
	assign counter_start_o = sys_mode & sys_ctl_i[upm_start_pos];
	assign counter_stop_o  = sys_mode & sys_ctl_i[upm_stop_pos];
	assign clock_divider_o = sys_mode ? sys_ctl_i[upm_divider_hi_pos:upm_divider_lo_pos] : '0;
	assign window_count_o  = sys_mode ? sys_ctl_i[upm_window_lo_pos +: WINDOW_BITS] : '0;
	assign debug_clk_en_o  = sys_mode & sys_ctl_i[upm_debug_pos(WINDOW_BITS)];
	assign cbb_pwr_en_o    = sys_mode ? pwr_en_dec : '0;
	assign cbb_addr_o      = sys_mode ? cbb_addr_i : '0;
	// load strobes are gated too
	assign cfg_capture_o   = sys_mode & cfg_capture_i;
	assign cfg_update_o    = sys_mode & cfg_update_i;

	// at most one CBB powered at a time
	a_pwr_en_onehot: assert property (
		@(posedge dfx_upm_func_clk_cg) disable iff (!dfx_upm_sys_rstn)
		$onehot0(cbb_pwr_en_o)
	);

endmodule

/* design/upm_top.sv */
// UPM system side top level
// load sequencer, config captures, system controller, event counter, result capture
`timescale 1ns/10ps

module upm_top #(
	parameter int WINDOW_BITS  = upm_pkg::upm_window_bits_p,
	parameter int COUNTER_BITS = upm_pkg::upm_counter_bits_p
) (
	input  logic                                             dfx_upm_func_clk_cg,
	input  logic                                             dfx_upm_sys_rstn,
	input  logic                                             sys_en_i,
	input  logic                                             tap_master_mode_i,
	input  logic [upm_pkg::upm_ctl_width_f(WINDOW_BITS)-1:0] sys_ctl_i,
	input  upm_pkg::upm_cbb_addr_t                           cbb_ctrl_i,
	input  upm_pkg::upm_cbb_pwr_t                            cbb_pwr_i,
	input  logic [1:0]                                       event_i,
	output logic                                             system_mode_o,
	output logic                                             window_mode_o,
	output logic                                             counter_start_o,
	output logic                                             counter_stop_o,
	output logic [upm_pkg::upm_divider_hi_pos-upm_pkg::upm_divider_lo_pos:0] clock_divider_o,
	output logic [WINDOW_BITS-1:0]                           window_count_o,
	output logic                                             debug_clk_en_o,
	output upm_pkg::upm_cbb_pwr_en_t                         cbb_pwr_en_o,
	output upm_pkg::upm_cbb_addr_t                           cbb_addr_o,
	output logic                                             cfg_capture_o,
	output logic                                             cfg_update_o,
	output logic [2*COUNTER_BITS+1:0]                        result_o,
	output logic [WINDOW_BITS+3:0]                           status_o
);
	import upm_pkg::*;

	localparam int CTL_W = upm_ctl_width_f(WINDOW_BITS);

	// sequencer strobes
	logic en_sync;
	logic cfg_capture;
	logic cbb_load;
	logic ctl_load;
	logic cfg_update;
	// held configuration
	logic [CTL_W-1:0] sys_ctl_held;
	upm_cbb_addr_t cbb_addr_held;
	upm_cbb_pwr_t cbb_pwr_held;
	// counter outputs
	logic [COUNTER_BITS-1:0] count0;
	logic [COUNTER_BITS-1:0] count1;
	logic [1:0] overflow;
	upm_cnt_state_t cnt_state;
	logic fsm_active;
	logic fsm_enable;
	logic [WINDOW_BITS-1:0] window_left;

	upm_load_sequencer u_load_sequencer (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.sys_en_i            (sys_en_i),
		.en_sync_o           (en_sync),
		.cfg_capture_o       (cfg_capture),
		.cbb_load_o          (cbb_load),
		.ctl_load_o          (ctl_load),
		.cfg_update_o        (cfg_update)
	);

	//----------------------------------------
	// configuration captures
	//----------------------------------------
	// control word loads last, at stage 9
	upm_cfg_capture #(.payload_t(logic [CTL_W-1:0])) u_ctl_capture (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.load_i              (ctl_load),
		.data_i              (sys_ctl_i),
		.data_o              (sys_ctl_held)
	);

	upm_cfg_capture #(.payload_t(upm_cbb_addr_t)) u_addr_capture (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.load_i              (cbb_load),
		.data_i              (cbb_ctrl_i),
		.data_o              (cbb_addr_held)
	);

	upm_cfg_capture #(.payload_t(upm_cbb_pwr_t)) u_pwr_capture (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.load_i              (cbb_load),
		.data_i              (cbb_pwr_i),
		.data_o              (cbb_pwr_held)
	);

	upm_system_controller #(.WINDOW_BITS(WINDOW_BITS)) u_system_controller (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.en_sync_i           (en_sync),
		.tap_master_mode_i   (tap_master_mode_i),
		.cfg_capture_i       (cfg_capture),
		.cfg_update_i        (cfg_update),
		.sys_ctl_i           (sys_ctl_held),
		.cbb_addr_i          (cbb_addr_held),
		.cbb_pwr_i           (cbb_pwr_held),
		.system_mode_o       (system_mode_o),
		.window_mode_o       (window_mode_o),
		.counter_start_o     (counter_start_o),
		.counter_stop_o      (counter_stop_o),
		.clock_divider_o     (clock_divider_o),
		.window_count_o      (window_count_o),
		.debug_clk_en_o      (debug_clk_en_o),
		.cbb_pwr_en_o        (cbb_pwr_en_o),
		.cbb_addr_o          (cbb_addr_o),
		.cfg_capture_o       (cfg_capture_o),
		.cfg_update_o        (cfg_update_o)
	);

	// counter runs from the gated controller fields
	upm_event_counter #(
		.WINDOW_BITS  (WINDOW_BITS),
		.COUNTER_BITS (COUNTER_BITS)
	) u_event_counter (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.start_i             (counter_start_o),
		.stop_i              (counter_stop_o),
		.window_mode_i       (window_mode_o),
		.divider_i           (clock_divider_o),
		.window_count_i      (window_count_o),
		.event_i             (event_i),
		.count0_o            (count0),
		.count1_o            (count1),
		.overflow_o          (overflow),
		.state_o             (cnt_state),
		.active_o            (fsm_active),
		.enable_o            (fsm_enable),
		.window_left_o       (window_left)
	);

	upm_result_capture #(
		.WINDOW_BITS  (WINDOW_BITS),
		.COUNTER_BITS (COUNTER_BITS)
	) u_result_capture (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.en_sync_i           (en_sync),
		.count0_i            (count0),
		.count1_i            (count1),
		.overflow_i          (overflow),
		.state_i             (cnt_state),
		.active_i            (fsm_active),
		.enable_i            (fsm_enable),
		.window_left_i       (window_left),
		.result_o            (result_o),
		.status_o            (status_o)
	);

endmodule

/* dv/upm_tb.sv */
// testbench for the UPM system side top level
// directed tests for reset, config load, tap master gating, counting and manual hold
`timescale 1ns/10ps

module upm_tb;
	import upm_pkg::*;

	localparam int window_bits  = 8;
	localparam int counter_bits = 4;
	localparam int ctl_w        = upm_ctl_width_f(window_bits);
	localparam int max_cycles   = 3000;
	localparam int update_limit = 40;

	logic dfx_upm_func_clk_cg;
	logic dfx_upm_sys_rstn;
	logic sys_en_i;
	logic tap_master_mode_i;
	logic [ctl_w-1:0] sys_ctl_i;
	upm_cbb_addr_t cbb_ctrl_i;
	upm_cbb_pwr_t cbb_pwr_i;
	logic [1:0] event_i;
	logic system_mode_o;
	logic window_mode_o;
	logic counter_start_o;
	logic counter_stop_o;
	logic [4:0] clock_divider_o;
	logic [window_bits-1:0] window_count_o;
	logic debug_clk_en_o;
	upm_cbb_pwr_en_t cbb_pwr_en_o;
	upm_cbb_addr_t cbb_addr_o;
	logic cfg_capture_o;
	logic cfg_update_o;
	logic [2*counter_bits+1:0] result_o;
	logic [window_bits+3:0] status_o;

	int seed;
	int error_count;
	int checks_done;
	int cycle_count = 0;
	// window load reused by the manual hold test
	logic [ctl_w-1:0] win_ctl;
	upm_cbb_addr_t win_addr;
	upm_cbb_pwr_t win_pwr;

	upm_top #(
		.WINDOW_BITS  (window_bits),
		.COUNTER_BITS (counter_bits)
	) UUT (
		.dfx_upm_func_clk_cg (dfx_upm_func_clk_cg),
		.dfx_upm_sys_rstn    (dfx_upm_sys_rstn),
		.sys_en_i            (sys_en_i),
		.tap_master_mode_i   (tap_master_mode_i),
		.sys_ctl_i           (sys_ctl_i),
		.cbb_ctrl_i          (cbb_ctrl_i),
		.cbb_pwr_i           (cbb_pwr_i),
		.event_i             (event_i),
		.system_mode_o       (system_mode_o),
		.window_mode_o       (window_mode_o),
		.counter_start_o     (counter_start_o),
		.counter_stop_o      (counter_stop_o),
		.clock_divider_o     (clock_divider_o),
		.window_count_o      (window_count_o),
		.debug_clk_en_o      (debug_clk_en_o),
		.cbb_pwr_en_o        (cbb_pwr_en_o),
		.cbb_addr_o          (cbb_addr_o),
		.cfg_capture_o       (cfg_capture_o),
		.cfg_update_o        (cfg_update_o),
		.result_o            (result_o),
		.status_o            (status_o)
	);

	initial begin
		dfx_upm_func_clk_cg = 1'b0;
		forever #50 dfx_upm_func_clk_cg = ~dfx_upm_func_clk_cg;
	end

	// run limit above the summed test lengths
	always @(posedge dfx_upm_func_clk_cg) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//----------------------------------------
	// compare tasks
	//----------------------------------------
	task automatic pwr_en_check(input string name, input upm_cbb_pwr_en_t exp,
		input upm_cbb_pwr_en_t act);
		checks_done++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic addr_check(input string name, input upm_cbb_addr_t exp,
		input upm_cbb_addr_t act);
		checks_done++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic field_check(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks_done++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic state_check(input string name, input upm_cnt_state_t exp,
		input upm_cnt_state_t act);
		checks_done++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic count_check(input string name, input logic [counter_bits-1:0] exp,
		input logic [counter_bits-1:0] act);
		checks_done++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// expected one hot CBB enable for a power select
	function automatic upm_cbb_pwr_en_t onehot_decode(input upm_cbb_pwr_t sel);
		upm_cbb_pwr_en_t v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			if (sel == i[3:0]) begin
				v[i] = 1'b1;
			end
		end
		return v;
	endfunction

	//----------------------------------------
	// load helpers
	//----------------------------------------
	task automatic start_load(input logic [ctl_w-1:0] ctl, input upm_cbb_addr_t addr,
		input upm_cbb_pwr_t pwr);
		@(negedge dfx_upm_func_clk_cg);
		sys_en_i = 1'b0;
		// drain the enable pipeline so the next rise is seen as an edge
		repeat (6) @(negedge dfx_upm_func_clk_cg);
		sys_ctl_i  = ctl;
		cbb_ctrl_i = addr;
		cbb_pwr_i  = pwr;
		sys_en_i   = 1'b1;
	endtask

	task automatic await_update();
		int waited;
		bit seen;
		bit capture_seen;
		waited = 0;
		seen = 0;
		capture_seen = 0;
		while (!seen && waited < update_limit) begin
			@(negedge dfx_upm_func_clk_cg);
			waited++;
			if (cfg_capture_o) begin
				capture_seen = 1;
			end
			if (cfg_update_o) begin
				seen = 1;
			end
		end
		if (!seen) begin
			error_count++;
			$display("cfg_update_o pulse did not arrive within %0d cycles", update_limit);
		end else if (!capture_seen) begin
			error_count++;
			$display("cfg_capture_o pulse did not come before cfg_update_o");
		end
	endtask

	// all zero word leaves start low and the hold bit clear
	task automatic clear_config();
		start_load('0, '0, '0);
		await_update();
	endtask

	task automatic wait_state(input upm_cnt_state_t s, input int limit);
		int waited;
		waited = 0;
		while (upm_cnt_state_t'(status_o[window_bits +: 2]) != s && waited < limit) begin
			@(negedge dfx_upm_func_clk_cg);
			waited++;
		end
		if (upm_cnt_state_t'(status_o[window_bits +: 2]) != s) begin
			error_count++;
			$display("counter state %0d not reached within %0d cycles", s, limit);
		end
	endtask

	task automatic outputs_zero_check();
		field_check("system_mode_o", 0, system_mode_o);
		field_check("window_mode_o", 0, window_mode_o);
		field_check("counter_start_o", 0, counter_start_o);
		field_check("counter_stop_o", 0, counter_stop_o);
		field_check("clock_divider_o", 0, clock_divider_o);
		field_check("window_count_o", 0, window_count_o);
		field_check("debug_clk_en_o", 0, debug_clk_en_o);
		pwr_en_check("cbb_pwr_en_o", '0, cbb_pwr_en_o);
		addr_check("cbb_addr_o", '0, cbb_addr_o);
		field_check("cfg_capture_o", 0, cfg_capture_o);
		field_check("cfg_update_o", 0, cfg_update_o);
	endtask

	// bit 0 window mode, bit 1 start, bit 2 stop, 7:3 divider, 15:8 window, top bit debug
	task automatic config_fields_check(input logic [ctl_w-1:0] ctl, input upm_cbb_addr_t addr,
		input upm_cbb_pwr_t pwr);
		field_check("system_mode_o", 1, system_mode_o);
		field_check("window_mode_o", ctl[0], window_mode_o);
		field_check("counter_start_o", ctl[1], counter_start_o);
		field_check("counter_stop_o", ctl[2], counter_stop_o);
		field_check("clock_divider_o", ctl[7:3], clock_divider_o);
		field_check("window_count_o", ctl[15:8], window_count_o);
		field_check("debug_clk_en_o", ctl[ctl_w-1], debug_clk_en_o);
		pwr_en_check("cbb_pwr_en_o", onehot_decode(pwr), cbb_pwr_en_o);
		addr_check("cbb_addr_o", addr, cbb_addr_o);
	endtask

	//----------------------------------------
	// directed tests
	//----------------------------------------
	task automatic reset_outputs_test();
		outputs_zero_check();
		field_check("result_o", 0, result_o);
		field_check("status_o", 0, status_o);
		state_check("cnt_state", CNT_IDLE, UUT.cnt_state);
	endtask

	task automatic random_config_test();
		logic [31:0] rnd;
		logic [ctl_w-1:0] ctl;
		upm_cbb_addr_t addr;
		upm_cbb_pwr_t pwr;
		repeat (4) begin
			rnd = $random(seed);
			ctl = rnd[ctl_w-1:0];
			rnd = $random(seed);
			addr = rnd[15:0];
			pwr = rnd[19:16];
			start_load(ctl, addr, pwr);
			await_update();
			config_fields_check(ctl, addr, pwr);
		end
	endtask

	task automatic tap_master_test();
		logic [31:0] rnd;
		@(negedge dfx_upm_func_clk_cg);
		tap_master_mode_i = 1'b1;
		repeat (2) @(negedge dfx_upm_func_clk_cg);
		rnd = $random(seed);
		start_load(rnd[ctl_w-1:0], rnd[31:16], rnd[3:0]);
		// pulses stay low over the whole 13 cycle strobe chain
		repeat (20) begin
			@(negedge dfx_upm_func_clk_cg);
			field_check("system_mode_o", 0, system_mode_o);
			field_check("cfg_capture_o", 0, cfg_capture_o);
			field_check("cfg_update_o", 0, cfg_update_o);
		end
		outputs_zero_check();
		tap_master_mode_i = 1'b0;
		repeat (2) @(negedge dfx_upm_func_clk_cg);
	endtask

	task automatic free_run_test();
		logic [ctl_w-1:0] ctl;
		int n;
		int exp0;
		int exp1;
		n = 11;
		exp0 = 0;
		exp1 = 0;
		ctl = '0;
		ctl[1] = 1'b1;
		clear_config();
		start_load(ctl, 16'h1234, 4'h3);
		await_update();
		// start edge lands on the next clock and the pulses follow
		for (int i = 0; i < 2 * n; i++) begin
			@(negedge dfx_upm_func_clk_cg);
			event_i[1] = 1'b1;
			event_i[0] = (i % 2 == 0);
			exp0 += event_i[0];
			exp1++;
		end
		@(negedge dfx_upm_func_clk_cg);
		event_i = '0;
		repeat (2) @(negedge dfx_upm_func_clk_cg);
		count_check("count0", counter_bits'(exp0), result_o[counter_bits-1:0]);
		field_check("overflow0", exp0 > 15, result_o[counter_bits]);
		count_check("count1", counter_bits'(exp1), result_o[counter_bits+1 +: counter_bits]);
		field_check("overflow1", exp1 > 15, result_o[2*counter_bits+1]);
		state_check("status state", CNT_RUN, upm_cnt_state_t'(status_o[window_bits +: 2]));
		// the start edge on re-enable clears the counts before stop lands
		ctl[2] = 1'b1;
		start_load(ctl, 16'h1234, 4'h3);
		await_update();
		repeat (3) @(negedge dfx_upm_func_clk_cg);
		state_check("status state", CNT_DONE, upm_cnt_state_t'(status_o[window_bits +: 2]));
		field_check("fsm_active", 0, status_o[window_bits+3]);
		field_check("result_o", 0, result_o);
	endtask

	task automatic window_test();
		logic [31:0] rnd;
		int d;
		int w;
		int expected;
		clear_config();
		@(negedge dfx_upm_func_clk_cg);
		event_i = 2'b11;
		rnd = $random(seed);
		d = int'(rnd[1:0]);
		rnd = $random(seed);
		// keep the count within the 4 bit counter
		w = 1 + int'(rnd[15:0] % (16 * (d + 1) - 1));
		expected = w / (d + 1);
		win_ctl = '0;
		win_ctl[0] = 1'b1;
		win_ctl[1] = 1'b1;
		win_ctl[7:3] = d[4:0];
		win_ctl[15:8] = w[7:0];
		win_ctl[ctl_w-1] = rnd[16];
		rnd = $random(seed);
		win_addr = rnd[15:0];
		win_pwr = rnd[23:20];
		start_load(win_ctl, win_addr, win_pwr);
		await_update();
		wait_state(CNT_RUN, 10);
		wait_state(CNT_DONE, w + 20);
		@(negedge dfx_upm_func_clk_cg);
		count_check("count0", counter_bits'(expected), result_o[counter_bits-1:0]);
		count_check("count1", counter_bits'(expected), result_o[counter_bits+1 +: counter_bits]);
		field_check("overflow0", 0, result_o[counter_bits]);
		field_check("overflow1", 0, result_o[2*counter_bits+1]);
		field_check("window_left", 0, status_o[window_bits-1:0]);
		state_check("status state", CNT_DONE, upm_cnt_state_t'(status_o[window_bits +: 2]));
		field_check("fsm_active", 0, status_o[window_bits+3]);
		field_check("fsm_enable", 1, status_o[window_bits+2]);
	endtask

	task automatic manual_hold_test();
		@(negedge dfx_upm_func_clk_cg);
		sys_en_i = 1'b0;
		// 3 sync stages plus the result register
		repeat (8) @(negedge dfx_upm_func_clk_cg);
		config_fields_check(win_ctl, win_addr, win_pwr);
		field_check("result_o", 0, result_o);
		field_check("status_o", 0, status_o);
		event_i = '0;
	endtask

	initial begin
		seed = 40023;
		error_count = 0;
		checks_done = 0;
		dfx_upm_sys_rstn = 1'b0;
		sys_en_i = 1'b0;
		tap_master_mode_i = 1'b0;
		sys_ctl_i = '0;
		cbb_ctrl_i = '0;
		cbb_pwr_i = '0;
		event_i = '0;
		win_ctl = '0;
		win_addr = '0;
		win_pwr = '0;
		repeat (10) @(negedge dfx_upm_func_clk_cg);
		dfx_upm_sys_rstn = 1'b1;
		repeat (2) @(negedge dfx_upm_func_clk_cg);

		reset_outputs_test();
		random_config_test();
		tap_master_test();
		free_run_test();
		window_test();
		manual_hold_test();

		$display("checks: %0d, errors: %0d", checks_done, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile the UPM testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal --top-module upm_tb -f build.f -o upm_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/upm_sim | tee /dev/stderr | grep -q "^SIMULATION PASSED$" \
	&& exit 0 \
	|| exit 1
